// ==== map117_pkg.sv ====
package map117_pkg;

	// CPU side buses.
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  cpu_dat_t;

	// PPU address bus, A13 included.
	typedef logic [13:0] ppu_addr_t;

	// One bank register.
	typedef logic [7:0]  bank_t;

	// Translated addresses into 512 KiB PRG and 256 KiB CHR.
	typedef logic [18:0] prg_addr_t;
	typedef logic [17:0] chr_addr_t;

	// Save-state register index.
	typedef logic [7:0]  ss_addr_t;

	// Bank register counts.
	localparam int unsigned PRG_BANKS = 4;
	localparam int unsigned CHR_BANKS = 8;

	// Power-on PRG banks, last four 8 KiB pages of the ROM.
	localparam bank_t PRG_BANK_RST [PRG_BANKS] = '{
		8'hFC,
		8'hFD,
		8'hFE,
		8'hFF
	};

	// Mapper number reported through the save-state port.
	localparam cpu_dat_t MAP_IDX = 8'd117;

	// Read value of unused save-state slots.
	localparam cpu_dat_t SS_NONE = 8'hFF;

endpackage

// ==== map117_irq_if.sv ====
interface map117_irq_if;
	import map117_pkg::*;

	// Strobes from the register decoder, one clock wide.
	logic     latch_wr;  // Load latch from wdat.
	logic     count_wr;  // Save-state load of the counter.
	logic     hist_wr;   // Save-state load of the A12 history.
	logic     flags_wr;  // Save-state load of enable and irq flag.
	logic     ack;       // C002 acknowledge.
	logic     reload;    // C003 counter reload.
	logic     enable_wr; // E000, acknowledge plus enable bit 0.
	cpu_dat_t wdat;

	// State of the scanline counter.
	cpu_dat_t   count;
	cpu_dat_t   latch;
	cpu_dat_t   a12_hist;
	logic [1:0] enable;
	logic       irq_flag;

	modport ctl (
		output latch_wr, count_wr, hist_wr, flags_wr, ack, reload, enable_wr, wdat,
		input  count, latch, a12_hist, enable, irq_flag
	);

	modport cnt (
		input  latch_wr, count_wr, hist_wr, flags_wr, ack, reload, enable_wr, wdat,
		output count, latch, a12_hist, enable, irq_flag
	);

endinterface

// ==== map117_regs.sv ====
module map117_regs (
	input  logic                  m2,
	input  logic                  map_rst,
	input  map117_pkg::cpu_addr_t cpu_addr,
	input  map117_pkg::cpu_dat_t  cpu_dat,
	input  logic                  cpu_rw,
	input  logic                  ss_act,
	input  logic                  ss_we,
	input  map117_pkg::ss_addr_t  ss_addr,
	output map117_pkg::cpu_dat_t  ss_rdat,
	output map117_pkg::bank_t     prg_bank [map117_pkg::PRG_BANKS],
	output map117_pkg::bank_t     chr_bank [map117_pkg::CHR_BANKS],
	output logic                  mirror,
	map117_irq_if.ctl             irq_bus
);
	import map117_pkg::*;

	// Save-state slots above the bank registers.
	localparam ss_addr_t SS_COUNT = 8'd12;
	localparam ss_addr_t SS_LATCH = 8'd13;
	localparam ss_addr_t SS_HIST  = 8'd14;
	localparam ss_addr_t SS_FLAGS = 8'd15;
	localparam ss_addr_t SS_MAP   = 8'd127;

	logic cpu_wr;
	logic ss_wr;
	logic prg_sel;
	logic chr_sel;
	logic ss_chr_sel;
	logic ss_prg_sel;

	assign cpu_wr = !cpu_rw && !ss_act; // Normal bus write.
	assign ss_wr  = ss_act && ss_we;    // Save-state restore.

	assign prg_sel    = {cpu_addr[15:2], 2'b00} == 16'h8000;
	assign chr_sel    = {cpu_addr[15:3], 3'b000} == 16'hA000;
	assign ss_chr_sel = ss_addr[7:3] == 5'd0; // Slots 0..7.
	assign ss_prg_sel = ss_addr[7:2] == 6'd2; // Slots 8..11.

	always_ff @(posedge m2) begin
		if (map_rst) begin
			prg_bank <= PRG_BANK_RST;
			for (int i = 0; i < CHR_BANKS; i++) begin
				chr_bank[i] <= bank_t'(i); // Identity CHR map.
			end
		end else if (ss_wr) begin
			if (ss_chr_sel)
				chr_bank[ss_addr[2:0]] <= cpu_dat;
			if (ss_prg_sel)
				prg_bank[ss_addr[1:0]] <= cpu_dat;
		end else if (cpu_wr) begin
			if (prg_sel)
				prg_bank[cpu_addr[1:0]] <= cpu_dat;
			if (chr_sel)
				chr_bank[cpu_addr[2:0]] <= cpu_dat;
		end
	end

	// Mirror survives reset.
	always_ff @(posedge m2) begin
		if (ss_wr && ss_addr == SS_FLAGS)
			mirror <= cpu_dat[3];
		else if (cpu_wr && cpu_addr == 16'hD000)
			mirror <= cpu_dat[0]; // 0 vertical, 1 horizontal.
	end

	// IRQ strobes, decoded here so the counter sees only commands.
	assign irq_bus.latch_wr  = (cpu_wr && cpu_addr == 16'hC001) ||
	                           (ss_wr && ss_addr == SS_LATCH);
	assign irq_bus.count_wr  = ss_wr && ss_addr == SS_COUNT;
	assign irq_bus.hist_wr   = ss_wr && ss_addr == SS_HIST;
	assign irq_bus.flags_wr  = ss_wr && ss_addr == SS_FLAGS;
	assign irq_bus.ack       = cpu_wr && cpu_addr == 16'hC002;
	assign irq_bus.reload    = cpu_wr && cpu_addr == 16'hC003;
	assign irq_bus.enable_wr = cpu_wr && cpu_addr == 16'hE000;
	assign irq_bus.wdat      = cpu_dat;

	always_comb begin
		if (ss_chr_sel)
			ss_rdat = chr_bank[ss_addr[2:0]];
		else if (ss_prg_sel)
			ss_rdat = prg_bank[ss_addr[1:0]];
		else begin
			case (ss_addr)
				SS_COUNT: ss_rdat = irq_bus.count;
				SS_LATCH: ss_rdat = irq_bus.latch;
				SS_HIST:  ss_rdat = irq_bus.a12_hist;
				SS_FLAGS: ss_rdat = {4'd0, mirror, irq_bus.enable, irq_bus.irq_flag};
				SS_MAP:   ss_rdat = MAP_IDX;
				default:  ss_rdat = SS_NONE;
			endcase
		end
	end

	// The counter applies strobes in a fixed order, so two at once would be ambiguous.
	a_one_strobe: assert property (@(posedge m2)
		$onehot0({irq_bus.latch_wr, irq_bus.count_wr, irq_bus.hist_wr, irq_bus.flags_wr,
		          irq_bus.ack, irq_bus.reload, irq_bus.enable_wr}));

endmodule

// ==== map117_irq.sv ====
module map117_irq #(
	parameter int unsigned A12_FILTER = 4
) (
	input  logic      m2,
	input  logic      map_rst,
	input  logic      ss_act,
	input  logic      ppu_a12,
	map117_irq_if.cnt irq_bus,
	output logic      irq
);
	import map117_pkg::*;

	cpu_dat_t   count;
	cpu_dat_t   latch;
	cpu_dat_t   a12_hist;
	logic [1:0] enable;
	logic       irq_flag;
	logic       a12_edge;

	// A12 high after A12_FILTER low samples.
	assign a12_edge = !ss_act && ppu_a12 && a12_hist[A12_FILTER-1:0] == '0;

	// Latch and history keep their contents through reset.
	always_ff @(posedge m2) begin
		if (irq_bus.latch_wr)
			latch <= irq_bus.wdat;
		if (irq_bus.hist_wr)
			a12_hist <= irq_bus.wdat;
		else if (!ss_act)
			a12_hist <= {a12_hist[6:0], ppu_a12}; // Newest sample in bit 0.
	end

	always_ff @(posedge m2) begin
		if (map_rst) begin
			count    <= '0;
			enable   <= 2'b00;
			irq_flag <= 1'b0;
		end else begin
			if (irq_bus.count_wr)
				count <= irq_bus.wdat;
			if (irq_bus.flags_wr) begin
				enable   <= irq_bus.wdat[2:1];
				irq_flag <= irq_bus.wdat[0];
			end
			if (irq_bus.ack)
				irq_flag <= 1'b0;
			if (irq_bus.reload) begin
				count     <= latch;
				enable[1] <= 1'b1; // Arm one expiry.
			end
			if (irq_bus.enable_wr) begin
				irq_flag  <= 1'b0;
				enable[0] <= irq_bus.wdat[0];
			end
			// Counting overrides a write in the same cycle.
			if (a12_edge && enable == 2'b11 && count != '0) begin
				count <= count - 8'd1;
				if (count == 8'd1) begin
					enable[1] <= 1'b0; // Needs a new C003.
					irq_flag  <= 1'b1;
				end
			end
		end
	end

	assign irq_bus.count    = count;
	assign irq_bus.latch    = latch;
	assign irq_bus.a12_hist = a12_hist;
	assign irq_bus.enable   = enable;
	assign irq_bus.irq_flag = irq_flag;

	assign irq = irq_flag;

	// Outside of restores, irq only rises when the count steps from 1 to 0.
	a_irq_on_expiry: assert property (@(posedge m2) disable iff (map_rst)
		($rose(irq_flag) && !$past(ss_act)) |-> (count == '0 && $past(count) == 8'd1));

endmodule

// ==== map117_addr.sv ====
module map117_addr (
	input  map117_pkg::cpu_addr_t cpu_addr,
	input  logic                  cpu_rw,
	input  logic                  cpu_ce,
	input  map117_pkg::ppu_addr_t ppu_addr,
	input  logic                  ppu_oe,
	input  logic                  ppu_we,
	input  logic                  chr_ram,
	input  map117_pkg::bank_t     prg_bank [map117_pkg::PRG_BANKS],
	input  map117_pkg::bank_t     chr_bank [map117_pkg::CHR_BANKS],
	input  logic                  mirror,
	output map117_pkg::prg_addr_t prg_addr,
	output logic                  prg_oe,
	output logic                  rom_ce,
	output map117_pkg::chr_addr_t chr_addr,
	output logic                  chr_ce,
	output logic                  chr_oe,
	output logic                  chr_we,
	output logic                  ciram_a10,
	output logic                  ciram_ce
);

	// Four 8 KiB PRG windows, 64 pages addressable.
	assign prg_addr = {prg_bank[cpu_addr[14:13]][5:0], cpu_addr[12:0]};
	assign prg_oe   = cpu_rw;
	assign rom_ce   = !cpu_ce;

	// Eight 1 KiB CHR windows.
	assign chr_addr = {chr_bank[ppu_addr[12:10]], ppu_addr[9:0]};

	// Pattern space is A13 low.
	assign ciram_ce = !ppu_addr[13];
	assign chr_ce   = ciram_ce;
	assign chr_oe   = !ppu_oe;

	// Writes only reach CHR RAM boards.
	assign chr_we = chr_ram && !ppu_we && ciram_ce;

	// A10 gives vertical mirroring, A11 horizontal.
	assign ciram_a10 = mirror ? ppu_addr[11] : ppu_addr[10];

endmodule

// ==== map117_top.sv ====
module map117_top #(
	parameter int unsigned A12_FILTER = 4
) (
	input  logic                  m2,
	input  logic                  map_rst,
	input  map117_pkg::cpu_addr_t cpu_addr,
	input  map117_pkg::cpu_dat_t  cpu_dat,
	input  logic                  cpu_rw,
	input  logic                  cpu_ce,
	input  map117_pkg::ppu_addr_t ppu_addr,
	input  logic                  ppu_oe,
	input  logic                  ppu_we,
	input  logic                  chr_ram,
	input  logic                  ss_act,
	input  logic                  ss_we,
	input  map117_pkg::ss_addr_t  ss_addr,
	output map117_pkg::prg_addr_t prg_addr,
	output logic                  prg_oe,
	output logic                  rom_ce,
	output map117_pkg::chr_addr_t chr_addr,
	output logic                  chr_ce,
	output logic                  chr_oe,
	output logic                  chr_we,
	output logic                  ciram_a10,
	output logic                  ciram_ce,
	output logic                  irq,
	output map117_pkg::cpu_dat_t  ss_rdat
);
	import map117_pkg::*;

	bank_t prg_bank [PRG_BANKS];
	bank_t chr_bank [CHR_BANKS];
	logic  mirror;

	map117_irq_if irq_bus ();

	map117_regs u_regs (
		.m2       (m2),
		.map_rst  (map_rst),
		.cpu_addr (cpu_addr),
		.cpu_dat  (cpu_dat),
		.cpu_rw   (cpu_rw),
		.ss_act   (ss_act),
		.ss_we    (ss_we),
		.ss_addr  (ss_addr),
		.ss_rdat  (ss_rdat),
		.prg_bank (prg_bank),
		.chr_bank (chr_bank),
		.mirror   (mirror),
		.irq_bus  (irq_bus.ctl)
	);

	map117_irq #(
		.A12_FILTER (A12_FILTER)
	) u_irq (
		.m2      (m2),
		.map_rst (map_rst),
		.ss_act  (ss_act),
		.ppu_a12 (ppu_addr[12]), // Scanline clock source.
		.irq_bus (irq_bus.cnt),
		.irq     (irq)
	);

	map117_addr u_addr (
		.cpu_addr  (cpu_addr),
		.cpu_rw    (cpu_rw),
		.cpu_ce    (cpu_ce),
		.ppu_addr  (ppu_addr),
		.ppu_oe    (ppu_oe),
		.ppu_we    (ppu_we),
		.chr_ram   (chr_ram),
		.prg_bank  (prg_bank),
		.chr_bank  (chr_bank),
		.mirror    (mirror),
		.prg_addr  (prg_addr),
		.prg_oe    (prg_oe),
		.rom_ce    (rom_ce),
		.chr_addr  (chr_addr),
		.chr_ce    (chr_ce),
		.chr_oe    (chr_oe),
		.chr_we    (chr_we),
		.ciram_a10 (ciram_a10),
		.ciram_ce  (ciram_ce)
	);

endmodule

// ==== tb_map117.sv ====
module tb_map117;
	timeunit 1ns;
	timeprecision 100ps;
	import map117_pkg::*;

	localparam int unsigned A12_FILTER = 4;
	localparam logic [7:0] FILTER_MASK = 8'hFF >> (8 - A12_FILTER);
	localparam int IRQ_TIMEOUT = 2000;

	logic m2, map_rst, cpu_rw, cpu_ce, ppu_oe, ppu_we, chr_ram, ss_act, ss_we;
	cpu_addr_t cpu_addr;
	cpu_dat_t cpu_dat;
	ppu_addr_t ppu_addr;
	ss_addr_t ss_addr;
	prg_addr_t prg_addr;
	chr_addr_t chr_addr;
	logic prg_oe, rom_ce, chr_ce, chr_oe, chr_we, ciram_a10, ciram_ce, irq;
	cpu_dat_t ss_rdat;

	// Reference model state.
	bank_t m_prg [4];
	bank_t m_chr [8];
	logic m_mirror;
	cpu_dat_t m_count, m_latch;
	cpu_dat_t m_hist = 8'd0; // Reset shifts in eight low samples.
	logic [1:0] m_en;
	logic m_irq;
	int errors = 0;
	int checks = 0;
	int seed_ret;

	map117_top #(.A12_FILTER(A12_FILTER)) u_dut (.*);

	initial begin
		m2 = 1'b0;
		forever #2 m2 = ~m2;
	end

	task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (exp === act) else begin
			errors++;
			$display("MISMATCH %s expected %0h actual %0h", name, exp, act);
		end
	endtask

	// One m2 edge of the model, using the inputs held since the falling edge.
	function automatic void model_clock();
		logic cpu_wr;
		logic ss_wr;
		logic edge_ok;
		cpu_dat_t old_cnt;
		logic [1:0] old_en;
		cpu_wr = !cpu_rw && !ss_act;
		ss_wr = ss_act && ss_we;
		edge_ok = !ss_act && ppu_addr[12] && (m_hist & FILTER_MASK) == 8'd0;
		old_cnt = m_count;
		old_en = m_en;
		if ((cpu_wr && cpu_addr == 16'hC001) || (ss_wr && ss_addr == 8'd13))
			m_latch = cpu_dat;
		if (ss_wr && ss_addr == 8'd14)
			m_hist = cpu_dat;
		else if (!ss_act)
			m_hist = {m_hist[6:0], ppu_addr[12]};
		if (ss_wr && ss_addr == 8'd15)
			m_mirror = cpu_dat[3];
		else if (cpu_wr && cpu_addr == 16'hD000)
			m_mirror = cpu_dat[0];
		if (map_rst) begin
			m_prg = '{8'hFC, 8'hFD, 8'hFE, 8'hFF};
			m_chr = '{8'd0, 8'd1, 8'd2, 8'd3, 8'd4, 8'd5, 8'd6, 8'd7};
			m_count = 8'd0;
			m_en = 2'b00;
			m_irq = 1'b0;
			return;
		end
		if (ss_wr) begin
			if (ss_addr < 8'd8)
				m_chr[ss_addr[2:0]] = cpu_dat;
			else if (ss_addr < 8'd12)
				m_prg[ss_addr[1:0]] = cpu_dat;
			else if (ss_addr == 8'd12)
				m_count = cpu_dat;
			else if (ss_addr == 8'd15) begin
				m_en = cpu_dat[2:1];
				m_irq = cpu_dat[0];
			end
		end else if (cpu_wr) begin
			if (cpu_addr[15:2] == 14'h2000)
				m_prg[cpu_addr[1:0]] = cpu_dat;
			if (cpu_addr[15:3] == 13'h1400)
				m_chr[cpu_addr[2:0]] = cpu_dat;
			if (cpu_addr == 16'hC002)
				m_irq = 1'b0;
			if (cpu_addr == 16'hC003) begin
				m_count = m_latch;
				m_en[1] = 1'b1;
			end
			if (cpu_addr == 16'hE000) begin
				m_irq = 1'b0;
				m_en[0] = cpu_dat[0];
			end
		end
		if (edge_ok && old_en == 2'b11 && old_cnt != 8'd0) begin
			m_count = old_cnt - 8'd1;
			if (old_cnt == 8'd1) begin
				m_en[1] = 1'b0;
				m_irq = 1'b1;
			end
		end
	endfunction

	// Ends on the falling edge, where the next inputs are driven.
	task automatic tick();
		@(posedge m2);
		model_clock();
		@(negedge m2);
	endtask

	task automatic cpu_write(input cpu_addr_t addr, input cpu_dat_t dat);
		cpu_addr = addr;
		cpu_dat = dat;
		cpu_rw = 1'b0;
		#1;
		expect_eq("cpu_write prg_oe", 1'b0, prg_oe); // No ROM output during a write.
		tick();
		cpu_rw = 1'b1;
	endtask

	function automatic cpu_dat_t ss_expect(input int idx);
		if (idx < 8)
			return m_chr[idx];
		if (idx < 12)
			return m_prg[idx - 8];
		case (idx)
			12: return m_count;
			13: return m_latch;
			14: return m_hist;
			15: return {4'd0, m_mirror, m_en, m_irq};
			127: return 8'd117;
			default: return 8'hFF;
		endcase
	endfunction

	// Random bus inputs, then compare every decoded output.
	task automatic random_access(input string name);
		cpu_addr = cpu_addr_t'($urandom);
		cpu_ce = $urandom_range(0, 1);
		ppu_addr = ppu_addr_t'($urandom);
		ppu_oe = $urandom_range(0, 1);
		ppu_we = $urandom_range(0, 1);
		chr_ram = $urandom_range(0, 1);
		#1;
		expect_eq({name, " prg_addr"}, {m_prg[cpu_addr[14:13]][5:0], cpu_addr[12:0]}, prg_addr);
		expect_eq({name, " chr_addr"}, {m_chr[ppu_addr[12:10]], ppu_addr[9:0]}, chr_addr);
		expect_eq({name, " ciram_a10"}, m_mirror ? ppu_addr[11] : ppu_addr[10], ciram_a10);
		expect_eq({name, " chr_we"}, chr_ram && !ppu_we && !ppu_addr[13], chr_we);
		expect_eq({name, " rom_ce"}, !cpu_ce, rom_ce);
		expect_eq({name, " ciram_ce"}, !ppu_addr[13], ciram_ce);
		expect_eq({name, " chr_ce"}, !ppu_addr[13], chr_ce);
		expect_eq({name, " chr_oe"}, !ppu_oe, chr_oe);
		expect_eq({name, " prg_oe"}, 1'b1, prg_oe); // CPU is reading.
		expect_eq({name, " irq"}, m_irq, irq);
		tick();
	endtask

	// Random A12 traffic, one high sample in four.
	task automatic a12_cycle(input string name);
		ppu_addr = ppu_addr_t'($urandom);
		ppu_addr[12] = ($urandom_range(0, 3) == 0);
		tick();
		expect_eq({name, " irq"}, m_irq, irq);
		expect_eq({name, " count"}, m_count, ss_rdat); // Index 12 is selected.
	endtask

	task automatic wait_irq(input string name);
		int n;
		n = 0;
		ss_addr = 8'd12;
		while (irq !== 1'b1 && !m_irq && n < IRQ_TIMEOUT) begin
			a12_cycle(name);
			n++;
		end
		assert (irq === 1'b1) else begin
			errors++;
			$display("%s: irq did not rise within %0d cycles", name, IRQ_TIMEOUT);
		end
	endtask

	initial begin
		seed_ret = $urandom(65);
		{map_rst, cpu_rw, cpu_ce, ppu_oe, ppu_we} = 5'b11111;
		{chr_ram, ss_act, ss_we} = 3'b000;
		cpu_addr = '0;
		cpu_dat = '0;
		ppu_addr = '0;
		ss_addr = '0;
		repeat (8) tick();
		map_rst = 1'b0;
		repeat (20) random_access("reset");

		repeat (40) begin
			if ($urandom_range(0, 1))
				cpu_write(16'h8000 + cpu_addr_t'($urandom_range(0, 3)), cpu_dat_t'($urandom));
			else
				cpu_write(16'hA000 + cpu_addr_t'($urandom_range(0, 7)), cpu_dat_t'($urandom));
			repeat (3) random_access("banks");
		end

		repeat (6) begin
			cpu_write(16'hD000, cpu_dat_t'($urandom));
			repeat (8) random_access("mirror");
		end

		cpu_write(16'hC001, cpu_dat_t'($urandom_range(1, 6)));
		cpu_write(16'hC003, 8'd0);
		cpu_write(16'hE000, 8'd1);
		wait_irq("irq_count");
		cpu_write($urandom_range(0, 1) ? 16'hC002 : 16'hE000, 8'd1);
		expect_eq("irq_ack", 1'b0, irq);
		// Restore a nonzero count without a C003 write.
		ss_act = 1'b1;
		ss_we = 1'b1;
		ss_addr = 8'd12;
		cpu_dat = cpu_dat_t'($urandom_range(1, 6));
		tick();
		ss_act = 1'b0;
		ss_we = 1'b0;
		repeat (100) a12_cycle("irq_no_rearm"); // Enable bit 1 is clear.
		cpu_write(16'hC003, 8'd0);
		wait_irq("irq_second");
		cpu_write(16'hC002, 8'd0);
		expect_eq("irq_ack2", 1'b0, irq);

		ss_act = 1'b1;
		ss_we = 1'b1;
		for (int i = 0; i < 16; i++) begin
			ss_addr = ss_addr_t'(i);
			cpu_dat = cpu_dat_t'($urandom);
			tick();
		end
		ss_we = 1'b0;
		for (int i = 0; i < 32; i++) begin
			ss_addr = (i < 16) ? ss_addr_t'(i) : ss_addr_t'($urandom_range(16, 255));
			if (i == 31)
				ss_addr = 8'd127;
			#1;
			expect_eq("ss_read", ss_expect(int'(ss_addr)), ss_rdat);
			tick();
		end
		ss_act = 1'b0;
		repeat (20) random_access("ss_restored");

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== flist.f ====
map117_pkg.sv
map117_irq_if.sv
map117_regs.sv
map117_irq.sv
map117_addr.sv
map117_top.sv
tb_map117.sv

// ==== Bender.yml ====
package:
  name: map117

sources:
  - map117_pkg.sv
  - map117_irq_if.sv
  - map117_regs.sv
  - map117_irq.sv
  - map117_addr.sv
  - map117_top.sv
  - target: simulation
    files:
      - tb_map117.sv
